// ==== design/vote_pkg.sv ====
`default_nettype none

package vote_pkg;

    // threshold width, also the lfsr sample width
    localparam int THR_W = 16;

    // rounds per core in one job
    localparam int ROUND_W = 12;

    // defaults picked up by the top level
    localparam int DEF_NUM_CORES = 4;
    // accumulator width
    localparam int DEF_SUM_W     = 20;
    // lfsr steps per trial
    localparam int DEF_SAMPLES   = 3;
    // issue queue depth per core
    localparam int DEF_CREDITS   = 2;

    // one signed vote
    // +1 or -1, zero in a cycle without a stored trial
    typedef logic signed [1:0] vote_t;

    localparam vote_t VOTE_POS  = 2'sb01;
    localparam vote_t VOTE_NEG  = 2'sb11;
    localparam vote_t VOTE_NONE = 2'sb00;

endpackage

`default_nettype wire

// ==== design/trial_dispatcher.sv ====
`default_nettype none

module trial_dispatcher #(
    parameter int NUM_CORES = 4,
    parameter int CREDITS   = 2
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          start,
    input  wire  [vote_pkg::ROUND_W-1:0] rounds,
    input  wire                          tie_bit,
    input  wire  [NUM_CORES-1:0]         credit_ret,
    output logic                         busy,
    output logic [NUM_CORES-1:0]         issue,
    output logic                         init,
    output logic                         init_even,
    output logic                         init_tie,
    output logic                         last
);

    import vote_pkg::*;

    // credit count 0..CREDITS
    localparam int CRD_W  = $clog2(CREDITS + 1);
    // returns in one cycle, 0..NUM_CORES
    localparam int RET_W  = $clog2(NUM_CORES + 1);
    // total trials of a job, NUM_CORES * rounds
    localparam int PEND_W = ROUND_W + RET_W;

    logic [ROUND_W-1:0] remaining [NUM_CORES];
    logic [CRD_W-1:0]   credit    [NUM_CORES];
    logic [PEND_W-1:0]  pending;
    logic [PEND_W-1:0]  job_total;
    logic [RET_W-1:0]   ret_cnt;
    logic               last_q;

    // start only taken when idle and the job has work
    assign init      = start && !busy && (rounds != '0);
    // total is odd only if core count and rounds are both odd
    assign init_even = (NUM_CORES % 2 == 0) || !rounds[0];
    assign init_tie  = tie_bit;
    assign job_total = PEND_W'(NUM_CORES) * PEND_W'(rounds);

    // trials coming back this cycle
    always_comb begin
        ret_cnt = '0;
        for (int k = 0; k < NUM_CORES; k++) begin
            ret_cnt = ret_cnt + RET_W'(credit_ret[k]);
        end
    end

    // one trial per core per cycle, gated by its own credit
    always_comb begin
        for (int k = 0; k < NUM_CORES; k++) begin
            issue[k] = busy && (remaining[k] != '0) && (credit[k] != '0);
        end
    end

    // final credit of the job lands this cycle
    assign last = busy && (ret_cnt != '0) && (PEND_W'(ret_cnt) == pending);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            pending <= '0;
            last_q  <= 1'b0;
        end else begin
            last_q <= last;
            if (init) begin
                busy    <= 1'b1;
                pending <= job_total;
            end else begin
                pending <= pending - PEND_W'(ret_cnt);
                // stay busy while the last votes go through the counter pipe
                if (last_q) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // per-core round and credit bookkeeping
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < NUM_CORES; k++) begin
                remaining[k] <= '0;
                credit[k]    <= CRD_W'(CREDITS);
            end
        end else begin
            for (int k = 0; k < NUM_CORES; k++) begin
                if (init) begin
                    remaining[k] <= rounds;
                end else if (issue[k]) begin
                    remaining[k] <= remaining[k] - ROUND_W'(1);
                end
                // issue takes a credit, a returned trial gives it back
                credit[k] <= credit[k] - CRD_W'(issue[k]) + CRD_W'(credit_ret[k]);
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/trial_core.sv ====
`default_nettype none

module trial_core #(
    parameter int CORE_ID = 0,
    parameter int SAMPLES = 3,
    parameter int CREDITS = 2
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire  [vote_pkg::THR_W-1:0] threshold,
    input  wire                        issue,
    output logic                       store,
    output logic                       result,
    output logic                       credit_ret
);

    import vote_pkg::*;

    // queued plus running trials, bounded by the credits
    localparam int Q_W    = $clog2(CREDITS + 1);
    localparam int STEP_W = (SAMPLES > 1) ? $clog2(SAMPLES) : 1;

    // distinct seed per core
    localparam logic [THR_W-1:0] SEED_RAW = THR_W'(32'hACE1 + CORE_ID * 32'h0101);
    // an all-zero lfsr would lock up
    localparam logic [THR_W-1:0] SEED     = (SEED_RAW == '0) ? THR_W'(1) : SEED_RAW;

    logic [Q_W-1:0]    q_cnt;
    logic [STEP_W-1:0] step;
    logic [THR_W-1:0]  lfsr;
    logic [THR_W-1:0]  lfsr_nxt;
    logic              working;
    logic              finish;

    // core works whenever a trial is queued
    assign working = (q_cnt != '0);
    // last lfsr step of the current trial
    assign finish  = working && (step == STEP_W'(SAMPLES - 1));

    // fibonacci lfsr, x^16 + x^14 + x^13 + x^11 + 1
    assign lfsr_nxt = {lfsr[THR_W-2:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};

    always_ff @(posedge clk) begin
        if (rst) begin
            q_cnt <= '0;
            step  <= '0;
            lfsr  <= SEED;
            store <= 1'b0;
        end else begin
            q_cnt <= q_cnt + Q_W'(issue) - Q_W'(finish);
            store <= finish;
            if (working) begin
                lfsr <= lfsr_nxt;
                // next queued trial follows without a gap
                if (finish) begin
                    step <= '0;
                end else begin
                    step <= step + STEP_W'(1);
                end
            end
        end
    end

    // +1 when the final sample is at or below the threshold
    always_ff @(posedge clk) begin
        if (finish) begin
            result <= (lfsr_nxt <= threshold);
        end
    end

    // a stored result frees its queue slot
    assign credit_ret = store;

endmodule

`default_nettype wire

// ==== design/vote_counter.sv ====
`default_nettype none

module vote_counter #(
    parameter int NUM_CORES = 4,
    parameter int SUM_W     = 20
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     init,
    input  wire                     init_even,
    input  wire                     init_tie,
    input  wire                     last,
    input  wire  [NUM_CORES-1:0]    store,
    input  wire  [NUM_CORES-1:0]    result,
    output logic signed [SUM_W-1:0] vote_sum,
    output logic                    sign_bit,
    output logic                    done
);

    import vote_pkg::*;

    vote_t                   votes [NUM_CORES];
    vote_t                   tie_start;
    logic signed [SUM_W-1:0] part_sum;
    logic signed [SUM_W-1:0] stage1;
    logic signed [SUM_W-1:0] acc;
    logic [1:0]              last_pipe;

    // result bit to vote, nothing stored gives zero
    always_comb begin
        for (int k = 0; k < NUM_CORES; k++) begin
            if (store[k]) begin
                votes[k] = result[k] ? VOTE_POS : VOTE_NEG;
            end else begin
                votes[k] = VOTE_NONE;
            end
        end
    end

    // adder tree input, votes sign-extended to the sum width
    always_comb begin
        part_sum = '0;
        for (int k = 0; k < NUM_CORES; k++) begin
            part_sum = part_sum + SUM_W'(votes[k]);
        end
    end

    // even total could end at zero, so bias by one
    // odd total never ties
    always_comb begin
        if (init_even) begin
            tie_start = init_tie ? VOTE_NEG : VOTE_POS;
        end else begin
            tie_start = VOTE_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage1    <= '0;
            acc       <= '0;
            last_pipe <= '0;
        end else begin
            // done lines up with the last vote reaching acc
            last_pipe <= {last_pipe[0], last};
            if (init) begin
                // new job, cores are idle here
                stage1 <= '0;
                acc    <= SUM_W'(tie_start);
            end else begin
                // stage 1 partial sum
                stage1 <= part_sum;
                // stage 2 accumulate
                acc    <= acc + stage1;
            end
        end
    end

    assign done     = last_pipe[1];
    assign vote_sum = acc;
    // negative sum means the -1 votes won
    assign sign_bit = acc[SUM_W-1];

endmodule

`default_nettype wire

// ==== design/vote_engine.sv ====
`default_nettype none

module vote_engine #(
    parameter int NUM_CORES = vote_pkg::DEF_NUM_CORES,
    parameter int SUM_W     = vote_pkg::DEF_SUM_W,
    parameter int SAMPLES   = vote_pkg::DEF_SAMPLES,
    parameter int CREDITS   = vote_pkg::DEF_CREDITS
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          start,
    input  wire  [vote_pkg::THR_W-1:0]   threshold,
    input  wire  [vote_pkg::ROUND_W-1:0] rounds,
    input  wire                          tie_bit,
    output logic                         busy,
    output logic                         done,
    output logic                         sign_bit,
    output logic signed [SUM_W-1:0]      vote_sum
);

    import vote_pkg::*;

    logic [THR_W-1:0]     thr_q;
    logic [NUM_CORES-1:0] issue;
    logic [NUM_CORES-1:0] store;
    logic [NUM_CORES-1:0] result;
    logic [NUM_CORES-1:0] credit_ret;
    logic                 init;
    logic                 init_even;
    logic                 init_tie;
    logic                 last;

    // job threshold, held for the whole run
    always_ff @(posedge clk) begin
        if (init) begin
            thr_q <= threshold;
        end
    end

    trial_dispatcher #(
        .NUM_CORES (NUM_CORES),
        .CREDITS   (CREDITS)
    ) u_dispatcher (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .rounds     (rounds),
        .tie_bit    (tie_bit),
        .credit_ret (credit_ret),
        .busy       (busy),
        .issue      (issue),
        .init       (init),
        .init_even  (init_even),
        .init_tie   (init_tie),
        .last       (last)
    );

    // one trial core per lane, each with its own seed
    for (genvar k = 0; k < NUM_CORES; k++) begin : g_core
        trial_core #(
            .CORE_ID (k),
            .SAMPLES (SAMPLES),
            .CREDITS (CREDITS)
        ) u_core (
            .clk        (clk),
            .rst        (rst),
            .threshold  (thr_q),
            .issue      (issue[k]),
            .store      (store[k]),
            .result     (result[k]),
            .credit_ret (credit_ret[k])
        );
    end

    vote_counter #(
        .NUM_CORES (NUM_CORES),
        .SUM_W     (SUM_W)
    ) u_counter (
        .clk       (clk),
        .rst       (rst),
        .init      (init),
        .init_even (init_even),
        .init_tie  (init_tie),
        .last      (last),
        .store     (store),
        .result    (result),
        .vote_sum  (vote_sum),
        .sign_bit  (sign_bit),
        .done      (done)
    );

endmodule

`default_nettype wire

// ==== testbench/vote_engine_assertions.sv ====
`default_nettype none

module vote_engine_assertions #(
    parameter int NUM_CORES = 4,
    parameter int CREDITS   = 2
) (
    input wire                 clk,
    input wire                 rst,
    input wire                 busy,
    input wire                 done,
    input wire [NUM_CORES-1:0] issue,
    input wire [NUM_CORES-1:0] credit_ret
);

    timeunit 1ns;
    timeprecision 1ps;

    // credits per core, rebuilt from the issue and return pulses
    int crd [NUM_CORES];
    int fired = 0;

    always_ff @(posedge clk) begin
        for (int k = 0; k < NUM_CORES; k++) begin
            if (rst) begin
                crd[k] <= CREDITS;
            end else begin
                crd[k] <= crd[k] - int'(issue[k]) + int'(credit_ret[k]);
            end
        end
    end

    for (genvar k = 0; k < NUM_CORES; k++) begin : g_lane
        // issue only into a free queue slot
        a_issue_credit: assert property (@(posedge clk) disable iff (rst)
            issue[k] |-> crd[k] > 0)
            else begin
                $error("issue to core %0d with no credit left", k);
                fired++;
            end
        // a return needs a trial in flight
        a_ret_bound: assert property (@(posedge clk) disable iff (rst)
            credit_ret[k] |-> crd[k] < CREDITS)
            else begin
                $error("credit return from core %0d with full credit", k);
                fired++;
            end
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            $error("done held longer than one cycle");
            fired++;
        end

    a_busy_done: assert property (@(posedge clk) disable iff (rst) done |-> $fell(busy))
        else begin
            $error("done without busy falling");
            fired++;
        end

    a_fall_done: assert property (@(posedge clk) disable iff (rst) $fell(busy) |-> done)
        else begin
            $error("busy fell without done");
            fired++;
        end

endmodule

bind vote_engine vote_engine_assertions #(
    .NUM_CORES (NUM_CORES),
    .CREDITS   (CREDITS)
) u_rules (
    .clk        (clk),
    .rst        (rst),
    .busy       (busy),
    .done       (done),
    .issue      (issue),
    .credit_ret (credit_ret)
);

`default_nettype wire

// ==== testbench/vote_engine_tb.sv ====
`default_nettype none

module vote_engine_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import vote_pkg::*;

    localparam int NUM_CORES = DEF_NUM_CORES;
    localparam int SUM_W     = DEF_SUM_W;
    localparam int SAMPLES   = DEF_SAMPLES;

    // rounds of the fixed jobs, 10 + 8 + 6 + 6 + 7 + 12
    localparam int FIXED_ROUNDS    = 49;
    localparam int RAND_JOBS       = 6;
    // power of two, used as a mask
    localparam int RAND_MAX_ROUNDS = 32;
    // start, pipeline drain and the checks around one job
    localparam int JOB_MARGIN      = 24;
    localparam int JOBS            = 6 + RAND_JOBS;
    // each core runs its rounds back to back, SAMPLES cycles apiece
    localparam int TIMEOUT_CYCLES  =
        (FIXED_ROUNDS + RAND_JOBS * RAND_MAX_ROUNDS) * SAMPLES + JOBS * JOB_MARGIN;

    localparam logic signed [SUM_W-1:0] ZERO_SUM = '0;

    logic                    clk;
    logic                    rst;
    logic                    start;
    logic [THR_W-1:0]        threshold;
    logic [ROUND_W-1:0]      rounds;
    logic                    tie_bit;
    logic                    busy;
    logic                    done;
    logic                    sign_bit;
    logic signed [SUM_W-1:0] vote_sum;

    int     checks;
    int     errors;
    int     cycles;
    integer seed;

    vote_engine uut (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .threshold (threshold),
        .rounds    (rounds),
        .tie_bit   (tie_bit),
        .busy      (busy),
        .done      (done),
        .sign_bit  (sign_bit),
        .vote_sum  (vote_sum)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // watchdog on the whole run
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the DUT never finished its job", cycles);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("Checks failed");
        $finish;
    end

    task automatic check_sum(input string name, input logic signed [SUM_W-1:0] got,
                             input logic signed [SUM_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    // accumulator start for n trials in total
    function automatic vote_t tie_bias(input int n, input logic tie);
        // odd totals cannot tie
        if (n % 2 != 0) begin
            return vote_t'(0);
        end
        return tie ? vote_t'(-1) : vote_t'(1);
    endfunction

    // only the two extreme thresholds give a known outcome
    function automatic logic signed [SUM_W-1:0] expected_sum(input logic [THR_W-1:0] thr,
                                                             input int rnd, input logic tie);
        int n;
        int total;
        n = NUM_CORES * rnd;
        // all ones accepts every sample, zero accepts none
        total = (thr == '1) ? n : -n;
        total = total + int'(tie_bias(n, tie));
        return SUM_W'(total);
    endfunction

    // one-cycle start pulse with the job fields
    task automatic start_job(input logic [THR_W-1:0] thr, input int rnd, input logic tie);
        @(posedge clk);
        start     <= 1'b1;
        threshold <= thr;
        rounds    <= ROUND_W'(rnd);
        tie_bit   <= tie;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // sampled on the falling edge, away from the updates
    task automatic wait_done;
        do begin
            @(negedge clk);
        end while (!done);
    endtask

    task automatic run_job(input string label, input logic [THR_W-1:0] thr,
                           input int rnd, input logic tie);
        logic signed [SUM_W-1:0] exp_sum;
        exp_sum = expected_sum(thr, rnd, tie);
        start_job(thr, rnd, tie);
        @(negedge clk);
        check_bit({label, " busy"}, busy, 1'b1);
        wait_done();
        // busy drops in the done cycle
        check_bit({label, " busy"}, busy, 1'b0);
        check_sum({label, " vote_sum"}, vote_sum, exp_sum);
        check_bit({label, " sign_bit"}, sign_bit, exp_sum < ZERO_SUM);
        @(negedge clk);
        check_bit({label, " done"}, done, 1'b0);
    endtask

    task automatic check_idle;
        @(negedge clk);
        check_bit("reset busy", busy, 1'b0);
        check_bit("reset done", done, 1'b0);
        check_sum("reset vote_sum", vote_sum, ZERO_SUM);
    endtask

    task automatic all_pos_votes;
        run_job("all pos", 16'hFFFF, 10, 1'b1);
    endtask

    // lfsr never yields zero, so every trial votes -1
    task automatic all_neg_votes;
        run_job("all neg", 16'h0000, 8, 1'b0);
    endtask

    task automatic tie_start_cases;
        run_job("tie even 0", 16'hFFFF, 6, 1'b0);
        run_job("tie even 1", 16'h0000, 6, 1'b1);
        // odd rounds, total still even with an even core count
        run_job("tie odd rounds", 16'hFFFF, 7, 1'b1);
    endtask

    task automatic start_while_busy;
        logic signed [SUM_W-1:0] exp_sum;
        exp_sum = expected_sum(16'hFFFF, 12, 1'b0);
        start_job(16'hFFFF, 12, 1'b0);
        repeat (4) @(posedge clk);
        // opposite job mid run, must be dropped
        start_job(16'h0000, 5, 1'b1);
        wait_done();
        check_sum("busy start vote_sum", vote_sum, exp_sum);
        check_bit("busy start sign_bit", sign_bit, 1'b0);
        // a taken second start would raise busy again
        repeat (6) begin
            @(negedge clk);
            check_bit("busy start busy", busy, 1'b0);
        end
    endtask

    task automatic random_back_to_back;
        logic [THR_W-1:0] thr;
        logic             tie;
        int               rnd;
        for (int j = 0; j < RAND_JOBS; j++) begin
            rnd = 1 + ($random(seed) & (RAND_MAX_ROUNDS - 1));
            thr = (($random(seed) & 1) != 0) ? 16'hFFFF : 16'h0000;
            tie = (($random(seed) & 1) != 0);
            run_job($sformatf("random job %0d", j), thr, rnd, tie);
        end
    endtask

    initial begin
        checks    = 0;
        errors    = 0;
        seed      = 13746;
        rst       = 1'b1;
        start     = 1'b0;
        threshold = '0;
        rounds    = '0;
        tie_bit   = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        check_idle();
        all_pos_votes();
        all_neg_votes();
        tie_start_cases();
        start_while_busy();
        random_back_to_back();
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, uut.u_rules.fired);
        if (errors == 0 && uut.u_rules.fired == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
design/vote_pkg.sv
design/trial_dispatcher.sv
design/trial_core.sv
design/vote_counter.sv
design/vote_engine.sv
testbench/vote_engine_assertions.sv
testbench/vote_engine_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := vote_engine_tb
RTL_TOP    := vote_engine
FILELIST   := build.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FLAGS      := --binary --assert --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only --timing --assert -Wall --timescale 1ns/1ps
SIM_ARGS   := +verilator+error+limit+100
PASS_MSG   := All checks passed
SRCS       := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
